/* all.f */
verilog/spi_cfg_pkg.sv
verilog/cfg_cmd_source.sv
verilog/cmd_fifo.sv
verilog/spi_cfg_link.sv
verilog/spi_cfg_top.sv
testbench/chip_reg_model.sv
testbench/spi_cfg_link_chk.sv
testbench/spi_cfg_tb.sv

/* testbench/spi_cfg_tb.sv */
`default_nettype none
`timescale 1ns/100ps

module spi_cfg_tb;

    // fifo deep enough to hold a whole select run
    localparam int FIFO_DEPTH = 8;
    localparam int SEQ_LEN    = 6;
    localparam spi_cfg_pkg::cfg_addr_t SEL_ADDR = 7'd58;
    localparam int NUM_REGS   = 128;
    localparam int N_WR       = 6;
    localparam int N_RD       = 4;
    localparam int BURST      = FIFO_DEPTH + 4;
    localparam int N_CMD      = 2 * N_WR + SEQ_LEN + 1 + N_RD + 2 * BURST;
    localparam logic [31:0] SEED = 32'd99529;

    logic clk;
    logic reset;
    logic host_wr;
    logic host_rd;
    logic seq_start;
    spi_cfg_pkg::cfg_addr_t host_addr;
    spi_cfg_pkg::cfg_data_t host_data;
    spi_cfg_pkg::cfg_data_t rd_data;
    logic spi_out;
    logic spi_din;
    logic spi_frame;
    logic spi_update;
    logic rd_valid;
    logic seq_busy;
    logic overflow;

    logic [31:0] lfsr;
    spi_cfg_pkg::cfg_data_t ref_regs [NUM_REGS];
    spi_cfg_pkg::cfg_data_t exp_q [$];
    string test_name;
    int err_cnt;
    int upd_cnt;
    int rdv_cnt;

    spi_cfg_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .SEQ_LEN    (SEQ_LEN),
        .SEL_ADDR   (SEL_ADDR)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .host_wr    (host_wr),
        .host_rd    (host_rd),
        .host_addr  (host_addr),
        .host_data  (host_data),
        .seq_start  (seq_start),
        .seq_busy   (seq_busy),
        .overflow   (overflow),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid),
        .spi_din    (spi_din),
        .spi_frame  (spi_frame),
        .spi_update (spi_update),
        .spi_out    (spi_out)
    );

    chip_reg_model #(
        .NUM_REGS (NUM_REGS)
    ) model (
        .clk        (clk),
        .reset      (reset),
        .spi_din    (spi_din),
        .spi_frame  (spi_frame),
        .spi_update (spi_update),
        .spi_out    (spi_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // galois lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic void expect_equal(input string name, input logic [31:0] exp,
                                         input logic [31:0] act);
        assert (act == exp) else begin
            err_cnt++;
            $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
        end
    endfunction

    task automatic strobe_cmd(input logic is_rd, input spi_cfg_pkg::cfg_addr_t a,
                              input spi_cfg_pkg::cfg_data_t d);
        @(posedge clk);
        host_wr   <= !is_rd;
        host_rd   <= is_rd;
        host_addr <= a;
        host_data <= d;
    endtask

    task automatic release_host();
        @(posedge clk);
        host_wr <= 1'b0;
        host_rd <= 1'b0;
    endtask

    task automatic write_and_wait(input spi_cfg_pkg::cfg_addr_t a,
                                  input spi_cfg_pkg::cfg_data_t d);
        int target;
        target = upd_cnt + 1;
        ref_regs[a] = d;
        strobe_cmd(1'b0, a, d);
        release_host();
        while (upd_cnt < target) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    task automatic read_and_wait(input spi_cfg_pkg::cfg_addr_t a,
                                 input spi_cfg_pkg::cfg_data_t exp);
        int target;
        target = rdv_cnt + 1;
        exp_q.push_back(exp);
        strobe_cmd(1'b1, a, '0);
        release_host();
        while (rdv_cnt < target) @(posedge clk);
    endtask

    // fifo empty and link idle, last pulse counted
    task automatic wait_drained();
        repeat (2) @(posedge clk);
        while (!DUT.fifo_empty || spi_frame) @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    task automatic check_reset_state(input string name);
        expect_equal(name, 0, {spi_frame, spi_update, rd_valid, seq_busy, overflow,
                               DUT.cmd_push, DUT.fifo_pop});
        expect_equal({name, " rd_data"}, 0, rd_data);
    endtask

    //////////////////////////////////////////////////
    // monitors and concurrent checks
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!reset) begin
            if (spi_update) begin
                upd_cnt <= upd_cnt + 1;
            end
            if (rd_valid) begin
                rdv_cnt <= rdv_cnt + 1;
                if (exp_q.size() == 0) begin
                    err_cnt++;
                    $display("rd_valid pulsed with no read outstanding in %s", test_name);
                end else begin
                    expect_equal({test_name, " rd_data"}, exp_q.pop_front(), rd_data);
                end
            end
        end
    end

    overflow_sticky: assert property (@(posedge clk) disable iff (reset)
        overflow |=> overflow)
        else begin
            err_cnt++;
            $display("ERROR overflow_sticky: expected 1, actual %0b", $sampled(overflow));
        end

    seq_start_busy: assert property (@(posedge clk) disable iff (reset)
        (seq_start && !seq_busy) |=> seq_busy)
        else begin
            err_cnt++;
            $display("ERROR seq_start_busy: expected 1, actual %0b", $sampled(seq_busy));
        end

    // watchdog sized from the command count
    initial begin
        repeat (N_CMD * 30 + 500) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial begin
        int base;
        int rbase;
        int total;
        spi_cfg_pkg::cfg_addr_t a;
        spi_cfg_pkg::cfg_addr_t wr_addr [N_WR];
        spi_cfg_pkg::cfg_addr_t burst_addr [BURST];
        spi_cfg_pkg::cfg_data_t burst_data [BURST];

        host_wr = 1'b0;
        host_rd = 1'b0;
        host_addr = '0;
        host_data = '0;
        seq_start = 1'b0;
        reset = 1'b1;
        lfsr = SEED;
        err_cnt = 0;
        upd_cnt = 0;
        rdv_cnt = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            ref_regs[i] = '0;
        end

        test_name = "reset";
        repeat (4) @(posedge clk);
        check_reset_state("reset_during");
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_reset_state("reset_after");

        // spaced writes, then read back
        test_name = "write_read";
        for (int i = 0; i < N_WR; i++) begin
            wr_addr[i] = lfsr_bits(spi_cfg_pkg::ADDR_W);
            write_and_wait(wr_addr[i], lfsr_bits(spi_cfg_pkg::DATA_W));
            expect_equal("write_read overflow", 0, overflow);
        end
        for (int i = 0; i < N_WR; i++) begin
            read_and_wait(wr_addr[i], ref_regs[wr_addr[i]]);
        end

        // class select run
        test_name = "select_seq";
        base = upd_cnt;
        @(posedge clk);
        seq_start <= 1'b1;
        @(posedge clk);
        seq_start <= 1'b0;
        while (upd_cnt < base + SEQ_LEN) @(posedge clk);
        expect_equal("select_seq seq_busy", 0, seq_busy);
        ref_regs[SEL_ADDR] = SEQ_LEN - 1;
        read_and_wait(SEL_ADDR, SEQ_LEN - 1);
        expect_equal("select_seq updates", SEQ_LEN, upd_cnt - base);

        // back to back reads
        test_name = "read_count";
        base = upd_cnt;
        rbase = rdv_cnt;
        for (int i = 0; i < N_RD; i++) begin
            a = lfsr_bits(spi_cfg_pkg::ADDR_W);
            exp_q.push_back(ref_regs[a]);
            strobe_cmd(1'b1, a, '0);
        end
        release_host();
        wait_drained();
        expect_equal("read_count rd_valid", N_RD, rdv_cnt - rbase);
        expect_equal("read_count updates", 0, upd_cnt - base);
        for (int i = 0; i < NUM_REGS; i++) begin
            expect_equal("reg_compare", ref_regs[i], model.regs[i]);
        end
        expect_equal("no_overflow", 0, overflow);

        // consecutive writes overrun the fifo
        test_name = "overflow";
        base = upd_cnt;
        for (int i = 0; i < BURST; i++) begin
            burst_addr[i] = lfsr_bits(spi_cfg_pkg::ADDR_W);
            burst_data[i] = lfsr_bits(spi_cfg_pkg::DATA_W);
            strobe_cmd(1'b0, burst_addr[i], burst_data[i]);
        end
        release_host();
        // one command in the link plus a full fifo get through
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            ref_regs[burst_addr[i]] = burst_data[i];
        end
        wait_drained();
        expect_equal("overflow flag", 1, overflow);
        expect_equal("overflow updates", FIFO_DEPTH + 1, upd_cnt - base);
        for (int i = 0; i < BURST; i++) begin
            read_and_wait(burst_addr[i], ref_regs[burst_addr[i]]);
        end

        repeat (5) @(posedge clk);
        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("%0d reads never returned rd_valid", exp_q.size());
        end
        total = err_cnt + DUT.u_link.link_chk.fail_cnt;
        $display("errors: %0d total, %0d testbench, %0d link checker",
                 total, err_cnt, DUT.u_link.link_chk.fail_cnt);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/spi_cfg_link_chk.sv */
`default_nettype none
`timescale 1ns/100ps

module spi_cfg_link_chk (
    input wire clk,
    input wire reset,
    input wire empty,
    input wire pop,
    input wire spi_frame,
    input wire spi_update,
    input wire rd_valid
);

    // failed assertions, summed into the result
    int fail_cnt = 0;

    // completion pulses last one cycle
    pulse_one_cycle: assert property (@(posedge clk) disable iff (reset)
        (spi_update || rd_valid) |=> !(spi_update || rd_valid))
        else begin
            fail_cnt++;
            $error("completion pulse held longer than one cycle");
        end

    // a pulse only right after a frame, and exactly one of the two
    pulse_after_frame: assert property (@(posedge clk) disable iff (reset)
        (spi_update || rd_valid || $fell(spi_frame)) |->
            ($fell(spi_frame) && (spi_update ^ rd_valid)))
        else begin
            fail_cnt++;
            $error("completion pulse missing, doubled or away from a frame end");
        end

    // a pop takes a queued command and starts its frame next edge
    pop_not_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> !empty ##1 $rose(spi_frame))
        else begin
            fail_cnt++;
            $error("pop raised while the FIFO is empty or no frame followed");
        end

    // frame window is exactly FRAME_LEN cycles
    frame_length: assert property (@(posedge clk) disable iff (reset)
        $rose(spi_frame) |-> spi_frame [*spi_cfg_pkg::FRAME_LEN] ##1 !spi_frame)
        else begin
            fail_cnt++;
            $error("spi_frame length differs from the frame size");
        end

endmodule

bind spi_cfg_link spi_cfg_link_chk link_chk (
    .clk        (clk),
    .reset      (reset),
    .empty      (empty),
    .pop        (pop),
    .spi_frame  (spi_frame),
    .spi_update (spi_update),
    .rd_valid   (rd_valid)
);

`default_nettype wire

/* testbench/chip_reg_model.sv */
`default_nettype none
`timescale 1ns/100ps

module chip_reg_model #(
    parameter int NUM_REGS = 128
) (
    input  wire  clk,
    input  wire  reset,
    input  wire  spi_din,
    input  wire  spi_frame,
    input  wire  spi_update,
    output logic spi_out
);

    spi_cfg_pkg::cfg_data_t  regs [NUM_REGS];
    spi_cfg_pkg::cfg_addr_t  addr;
    spi_cfg_pkg::cfg_data_t  data;
    spi_cfg_pkg::frame_cnt_t bit_pos;

    // register bit k goes out in data cycle k
    assign spi_out = (spi_frame && bit_pos >= spi_cfg_pkg::ADDR_W) ?
                     regs[addr][bit_pos - spi_cfg_pkg::ADDR_W] : 1'b0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bit_pos <= '0;
            addr    <= '0;
            data    <= '0;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (spi_frame) begin
                bit_pos <= bit_pos + 1'b1;
                // address field first, lsb first
                if (bit_pos < spi_cfg_pkg::ADDR_W) begin
                    addr[bit_pos] <= spi_din;
                end else begin
                    data[bit_pos - spi_cfg_pkg::ADDR_W] <= spi_din;
                end
            end else begin
                bit_pos <= '0;
            end
            // write strobe after a write frame
            if (spi_update) begin
                regs[addr] <= data;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/spi_cfg_top.sv */
`default_nettype none
`timescale 1ns/100ps

module spi_cfg_top #(
    parameter int                     FIFO_DEPTH = 4,
    parameter int                     SEQ_LEN    = 20,
    parameter spi_cfg_pkg::cfg_addr_t SEL_ADDR   = 7'd58
) (
    input  wire                    clk,
    input  wire                    reset,
    // host side
    input  wire                    host_wr,
    input  wire                    host_rd,
    input  spi_cfg_pkg::cfg_addr_t host_addr,
    input  spi_cfg_pkg::cfg_data_t host_data,
    input  wire                    seq_start,
    output logic                   seq_busy,
    output logic                   overflow,
    output spi_cfg_pkg::cfg_data_t rd_data,
    output logic                   rd_valid,
    // chip side
    output logic                   spi_din,
    output logic                   spi_frame,
    output logic                   spi_update,
    input  wire                    spi_out
);

    //////////////////////////////////////////////////
    // source -> fifo -> link
    //////////////////////////////////////////////////

    logic                  cmd_push;
    spi_cfg_pkg::cfg_cmd_t cmd;
    logic                  fifo_empty;
    spi_cfg_pkg::cfg_cmd_t fifo_head;
    logic                  fifo_pop;

    // host strobes and class select run
    cfg_cmd_source #(
        .SEQ_LEN  (SEQ_LEN),
        .SEL_ADDR (SEL_ADDR)
    ) u_source (
        .clk       (clk),
        .reset     (reset),
        .host_wr   (host_wr),
        .host_rd   (host_rd),
        .host_addr (host_addr),
        .host_data (host_data),
        .seq_start (seq_start),
        .cmd_push  (cmd_push),
        .cmd       (cmd),
        .seq_busy  (seq_busy)
    );

    // command buffer, drops on full
    cmd_fifo #(
        .payload_t  (spi_cfg_pkg::cfg_cmd_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (cmd_push),
        .din      (cmd),
        .pop      (fifo_pop),
        .head     (fifo_head),
        .empty    (fifo_empty),
        .overflow (overflow)
    );

    // serial shifter to the chip
    spi_cfg_link u_link (
        .clk        (clk),
        .reset      (reset),
        .empty      (fifo_empty),
        .head       (fifo_head),
        .spi_out    (spi_out),
        .pop        (fifo_pop),
        .spi_din    (spi_din),
        .spi_frame  (spi_frame),
        .spi_update (spi_update),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

endmodule

`default_nettype wire

/* verilog/spi_cfg_link.sv */
`default_nettype none
`timescale 1ns/100ps

module spi_cfg_link (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    empty,
    input  spi_cfg_pkg::cfg_cmd_t  head,
    input  wire                    spi_out,
    output logic                   pop,
    output logic                   spi_din,
    output logic                   spi_frame,
    output logic                   spi_update,
    output spi_cfg_pkg::cfg_data_t rd_data,
    output logic                   rd_valid
);

    // frame in progress
    logic busy;
    // current frame is a read
    logic is_rd;
    spi_cfg_pkg::frame_cnt_t bit_cnt;

    // outgoing frame, bit 0 is on the wire
    logic [spi_cfg_pkg::FRAME_LEN-1:0] shreg;

    // read word being assembled, lsb first
    spi_cfg_pkg::cfg_data_t cap;
    spi_cfg_pkg::cfg_data_t cap_next;

    logic last_bit;
    logic in_data;

    //////////////////////////////////////////////////
    // handshake and frame decode
    //////////////////////////////////////////////////

    // take the next command as soon as idle
    assign pop = ~busy & ~empty;

    assign last_bit = busy &
                      (bit_cnt == spi_cfg_pkg::frame_cnt_t'(spi_cfg_pkg::FRAME_LEN - 1));

    // data field of a read, chip drives spi_out
    assign in_data = busy & is_rd &
                     (bit_cnt >= spi_cfg_pkg::frame_cnt_t'(spi_cfg_pkg::ADDR_W));

    // new bit enters at the top, bit k lands at k after 16 shifts
    assign cap_next = {spi_out, cap[spi_cfg_pkg::DATA_W-1:1]};

    // serial pins
    assign spi_frame = busy;
    assign spi_din   = busy & shreg[0];

    //////////////////////////////////////////////////
    // control and result registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy       <= 1'b0;
            is_rd      <= 1'b0;
            bit_cnt    <= '0;
            spi_update <= 1'b0;
            rd_valid   <= 1'b0;
            rd_data    <= '0;
        end else begin
            // completion pulses, one cycle after the last bit
            spi_update <= last_bit & ~is_rd;
            rd_valid   <= last_bit & is_rd;

            if (pop) begin
                busy    <= 1'b1;
                is_rd   <= head.rd;
                bit_cnt <= '0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (last_bit) begin
                    busy <= 1'b0;
                end
            end

            // last data bit sampled together with the word
            if (last_bit && is_rd) begin
                rd_data <= cap_next;
            end
        end
    end

    //////////////////////////////////////////////////
    // shift datapath
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (pop) begin
            // address first, then data or zeros for a read
            if (head.rd) begin
                shreg <= {spi_cfg_pkg::DATA_W'(0), head.addr};
            end else begin
                shreg <= {head.data, head.addr};
            end
        end else if (busy) begin
            shreg <= shreg >> 1;
        end

        if (in_data) begin
            cap <= cap_next;
        end
    end

endmodule

`default_nettype wire

/* verilog/cmd_fifo.sv */
`default_nettype none
`timescale 1ns/100ps

module cmd_fifo #(
    parameter type payload_t  = logic [7:0],
    parameter int  FIFO_DEPTH = 4
) (
    input  wire      clk,
    input  wire      reset,
    input  wire      push,
    input  payload_t din,
    input  wire      pop,
    output payload_t head,
    output logic     empty,
    output logic     overflow
);

    // depth is a power of two, pointers wrap on their own
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    payload_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push_ok;
    logic             pop_ok;

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);

    // full plus pop frees the slot in the same cycle
    assign push_ok = push & (~full | pop);
    assign pop_ok  = pop & ~empty;

    // head valid whenever not empty
    assign head = mem[rd_ptr];

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= din;
        end
    end

    //////////////////////////////////////////////////
    // pointers, occupancy, overflow
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // dropped command, sticky until reset
            if (push && !push_ok) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/cfg_cmd_source.sv */
`default_nettype none
`timescale 1ns/100ps

module cfg_cmd_source #(
    parameter int                    SEQ_LEN  = 20,
    parameter spi_cfg_pkg::cfg_addr_t SEL_ADDR = 7'd58
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    host_wr,
    input  wire                    host_rd,
    input  spi_cfg_pkg::cfg_addr_t host_addr,
    input  spi_cfg_pkg::cfg_data_t host_data,
    input  wire                    seq_start,
    output logic                   cmd_push,
    output spi_cfg_pkg::cfg_cmd_t  cmd,
    output logic                   seq_busy
);

    // index counter wide enough for SEQ_LEN-1
    localparam int IDX_W = (SEQ_LEN > 1) ? $clog2(SEQ_LEN) : 1;

    logic             host_any;
    logic [IDX_W-1:0] seq_idx;

    // host strobes win over a sequence step
    assign host_any = host_wr | host_rd;

    //////////////////////////////////////////////////
    // push strobe and sequence control
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmd_push <= 1'b0;
            seq_busy <= 1'b0;
            seq_idx  <= '0;
        end else begin
            // one command per cycle, host first
            cmd_push <= host_any | seq_busy;
            if (seq_busy && !host_any) begin
                // select write goes out this cycle
                if (seq_idx == IDX_W'(SEQ_LEN - 1)) begin
                    seq_busy <= 1'b0;
                    seq_idx  <= '0;
                end else begin
                    seq_idx <= seq_idx + 1'b1;
                end
            end else if (!seq_busy && seq_start) begin
                // start ignored while a run is active
                seq_busy <= 1'b1;
                seq_idx  <= '0;
            end
        end
    end

    //////////////////////////////////////////////////
    // command payload
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (host_wr) begin
            cmd <= '{rd: 1'b0, addr: host_addr, data: host_data};
        end else if (host_rd) begin
            // read frame sends zero data
            cmd <= '{rd: 1'b1, addr: host_addr, data: '0};
        end else if (seq_busy) begin
            // class select, data is the step index
            cmd <= '{rd: 1'b0, addr: SEL_ADDR, data: spi_cfg_pkg::cfg_data_t'(seq_idx)};
        end
    end

endmodule

`default_nettype wire

/* verilog/spi_cfg_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////
// config link widths and command format
//////////////////////////////////////////////////

package spi_cfg_pkg;

    // chip register space
    localparam int ADDR_W = 7;
    localparam int DATA_W = 16;

    // one frame carries address then data, lsb first
    localparam int FRAME_LEN = ADDR_W + DATA_W;

    typedef logic [ADDR_W-1:0] cfg_addr_t;
    typedef logic [DATA_W-1:0] cfg_data_t;

    // bit position inside a frame, 0 .. FRAME_LEN-1
    typedef logic [$clog2(FRAME_LEN)-1:0] frame_cnt_t;

    // one queued command
    // rd set means read frame, data field ignored
    typedef struct packed {
        logic      rd;
        cfg_addr_t addr;
        cfg_data_t data;
    } cfg_cmd_t;

endpackage

`default_nettype wire
